// ==== csh_params.svh ====
`ifndef CSH_PARAMS_SVH
`define CSH_PARAMS_SVH

// Number of cache ways
`define CSH_WAYS 4

// Diagnostic window select width
`define CSH_DIAG_SEL_W 3

// Diagnostic readout word width
`define CSH_DIAG_W 8

`endif

// ==== cshPkg.sv ====
`include "csh_params.svh"

package cshPkg;

  // One-hot cycle type, MB in the top bit
  typedef logic [3:0] cycTypeT;

  localparam int cycMb   = 3;
  localparam int cycChan = 2;
  localparam int cycEbox = 1;
  localparam int cycCca  = 0;

  typedef logic [`CSH_WAYS-1:0] wayVecT;

  // Index of the least recently used way
  typedef logic [$clog2(`CSH_WAYS)-1:0] lruT;

  typedef logic [`CSH_DIAG_SEL_W-1:0] diagSelT;
  typedef logic [`CSH_DIAG_W-1:0] diagWordT;

  // Readable diagnostic windows
  localparam diagSelT diagSelCycle  = 'd0;
  localparam diagSelT diagSelResult = 'd1;

  // Timing chain, one state per T flop
  typedef enum logic [2:0] {IDLE, T0, T1, T2, T3} cshStateT;

endpackage

// ==== cshArbiter.sv ====
`timescale 1ns/1ps
`include "csh_params.svh"

module cshArbiter (
  input  logic            clk,
  input  logic            rstN,
  input  logic            mbReq,
  input  logic            chanReq,
  input  logic            eboxReq,
  input  logic            ccaReq,
  input  logic            readyToGo,
  output logic            grant,
  output cshPkg::cycTypeT cycType
);

  import cshPkg::*;

  cycTypeT winner;
  logic    anyReq;

  // Fixed priority, MB over channel over EBOX over CCA
  always_comb begin
    winner = '0;
    if (mbReq) begin
      winner[cycMb] = 1'b1;
    end else if (chanReq) begin
      winner[cycChan] = 1'b1;
    end else if (eboxReq) begin
      winner[cycEbox] = 1'b1;
    end else if (ccaReq) begin
      winner[cycCca] = 1'b1;
    end
  end

  assign anyReq = mbReq | chanReq | eboxReq | ccaReq;

  // Only granted while the cache is idle
  assign grant = readyToGo & anyReq;

  // Cycle type hold register
  // Loads the winner while ready, so an idle clock with no request clears it
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cycType <= '0;
    end else if (readyToGo) begin
      cycType <= winner;
    end
  end

  // At most one cycle type ever held
  cycTypeOneHot: assert property (
    @(posedge clk) disable iff (!rstN)
    $onehot0(cycType)
  ) else $error("cycType holds more than one cycle type");

  // A grant always leaves a single cycle type held through the cycle
  grantLoadsType: assert property (
    @(posedge clk) disable iff (!rstN)
    grant |=> $onehot(cycType) ##1 $stable(cycType) ##1 $stable(cycType)
      ##1 $stable(cycType)
  ) else $error("cycType not held after grant");

endmodule

// ==== cshTiming.sv ====
`timescale 1ns/1ps
`include "csh_params.svh"

module cshTiming (
  input  logic             clk,
  input  logic             rstN,
  input  logic             grant,
  output cshPkg::cshStateT state,
  output logic             readyToGo
);

  import cshPkg::*;

  cshStateT stateNext;

  // T0 through T3 in fixed order, no early exit
  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (grant) begin
          stateNext = T0;
        end
      end
      T0: stateNext = T1;
      T1: stateNext = T2;
      T2: stateNext = T3;
      T3: stateNext = IDLE;
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= IDLE;
    end else begin
      state <= stateNext;
    end
  end

  // Cache idle
  assign readyToGo = (state == IDLE);

  // Arbiter must not grant while a cycle is in progress
  grantOnlyIdle: assert property (
    @(posedge clk) disable iff (!rstN)
    grant |-> state == IDLE
  ) else $error("grant seen outside IDLE");

endmodule

// ==== cshLookup.sv ====
`timescale 1ns/1ps
`include "csh_params.svh"

module cshLookup (
  input  logic             clk,
  input  logic             rstN,
  input  cshPkg::cshStateT state,
  input  cshPkg::cycTypeT  cycType,
  input  cshPkg::wayVecT   validMatch,
  input  cshPkg::wayVecT   anyWritten,
  input  cshPkg::wayVecT   wordValid,
  input  cshPkg::lruT      lruWay,
  input  logic             cacheBit,
  output logic             mboxResp,
  output logic             coreRdReq,
  output logic             writeback,
  output logic             chanHit,
  output logic             ccaInval,
  output logic             ccaWriteback
);

  import cshPkg::*;

  logic       anyValidMatch;
  logic       readFound;
  logic       anyWrittenMatch;
  logic       lruWritten;
  logic [5:0] resultNext;
  logic [5:0] resultQ;

  // Way reductions
  assign anyValidMatch   = |validMatch;
  assign readFound       = |(validMatch & wordValid);
  assign anyWrittenMatch = |(validMatch & anyWritten);

  // Victim way dirty
  assign lruWritten = anyWritten[lruWay];

  // Decision, bits in port order mboxResp down to ccaWriteback
  always_comb begin
    resultNext = '0;
    if (state == T2) begin
      if (cycType[cycEbox]) begin
        if (readFound) begin
          resultNext[5] = 1'b1;
        end else if (!anyValidMatch && cacheBit && lruWritten) begin
          resultNext[3] = 1'b1;
        end else begin
          // Partial hit or clean miss both go to core
          resultNext[4] = 1'b1;
        end
      end
      if (cycType[cycChan]) begin
        resultNext[2] = anyValidMatch;
      end
      if (cycType[cycCca]) begin
        if (anyWrittenMatch) begin
          resultNext[0] = 1'b1;
        end else begin
          resultNext[1] = anyValidMatch;
        end
      end
    end
  end

  // Next is zero outside T2, so the pulse drops on the edge leaving T3
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resultQ <= '0;
    end else begin
      resultQ <= resultNext;
    end
  end

  assign mboxResp     = resultQ[5];
  assign coreRdReq    = resultQ[4];
  assign writeback    = resultQ[3];
  assign chanHit      = resultQ[2];
  assign ccaInval     = resultQ[1];
  assign ccaWriteback = resultQ[0];

  resultOneHot: assert property (
    @(posedge clk) disable iff (!rstN)
    $onehot0(resultQ)
  ) else $error("more than one result pulse");

  // Pulses line up with T3 of the timing chain
  resultInT3: assert property (
    @(posedge clk) disable iff (!rstN)
    (|resultQ) |-> state == T3
  ) else $error("result pulse outside T3");

endmodule

// ==== cshDiag.sv ====
`timescale 1ns/1ps
`include "csh_params.svh"

module cshDiag (
  input  logic             clk,
  input  logic             rstN,
  input  logic             diagLoad,
  input  cshPkg::diagSelT  diagSelIn,
  input  logic             diagEn,
  input  cshPkg::cshStateT state,
  input  cshPkg::cycTypeT  cycType,
  input  logic             mboxResp,
  input  logic             coreRdReq,
  input  logic             writeback,
  input  logic             chanHit,
  input  logic             ccaInval,
  input  logic             ccaWriteback,
  output cshPkg::diagWordT diagData
);

  import cshPkg::*;

  diagSelT    selQ;
  logic [3:0] stateBits;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      selQ <= '0;
    end else if (diagLoad) begin
      selQ <= diagSelIn;
    end
  end

  // T flops as seen on the old readout, idle reads all zero
  always_comb begin
    case (state)
      T0: stateBits = 4'b0001;
      T1: stateBits = 4'b0010;
      T2: stateBits = 4'b0100;
      T3: stateBits = 4'b1000;
      default: stateBits = 4'b0000;
    endcase
  end

  always_comb begin
    diagData = '0;
    if (diagEn) begin
      case (selQ)
        diagSelCycle: diagData = diagWordT'({cycType, stateBits});
        diagSelResult: begin
          diagData = diagWordT'({mboxResp, coreRdReq, writeback,
                                 chanHit, ccaInval, ccaWriteback});
        end
        default: diagData = '0;
      endcase
    end
  end

endmodule

// ==== csh.sv ====
`timescale 1ns/1ps
`include "csh_params.svh"

module csh (
  input  logic             clk,
  input  logic             rstN,
  input  logic             mbReq,
  input  logic             chanReq,
  input  logic             eboxReq,
  input  logic             ccaReq,
  input  cshPkg::wayVecT   validMatch,
  input  cshPkg::wayVecT   anyWritten,
  input  cshPkg::wayVecT   wordValid,
  input  cshPkg::lruT      lruWay,
  input  logic             cacheBit,
  input  logic             diagLoad,
  input  cshPkg::diagSelT  diagSelIn,
  input  logic             diagEn,
  output logic             mboxResp,
  output logic             coreRdReq,
  output logic             writeback,
  output logic             chanHit,
  output logic             ccaInval,
  output logic             ccaWriteback,
  output cshPkg::diagWordT diagData
);

  import cshPkg::*;

  cycTypeT  cycType;
  cshStateT state;
  logic     grant;
  logic     readyToGo;

  cshArbiter uArbiter (
    .clk       (clk),
    .rstN      (rstN),
    .mbReq     (mbReq),
    .chanReq   (chanReq),
    .eboxReq   (eboxReq),
    .ccaReq    (ccaReq),
    .readyToGo (readyToGo),
    .grant     (grant),
    .cycType   (cycType)
  );

  cshTiming uTiming (
    .clk       (clk),
    .rstN      (rstN),
    .grant     (grant),
    .state     (state),
    .readyToGo (readyToGo)
  );

  cshLookup uLookup (
    .clk          (clk),
    .rstN         (rstN),
    .state        (state),
    .cycType      (cycType),
    .validMatch   (validMatch),
    .anyWritten   (anyWritten),
    .wordValid    (wordValid),
    .lruWay       (lruWay),
    .cacheBit     (cacheBit),
    .mboxResp     (mboxResp),
    .coreRdReq    (coreRdReq),
    .writeback    (writeback),
    .chanHit      (chanHit),
    .ccaInval     (ccaInval),
    .ccaWriteback (ccaWriteback)
  );

  cshDiag uDiag (
    .clk          (clk),
    .rstN         (rstN),
    .diagLoad     (diagLoad),
    .diagSelIn    (diagSelIn),
    .diagEn       (diagEn),
    .state        (state),
    .cycType      (cycType),
    .mboxResp     (mboxResp),
    .coreRdReq    (coreRdReq),
    .writeback    (writeback),
    .chanHit      (chanHit),
    .ccaInval     (ccaInval),
    .ccaWriteback (ccaWriteback),
    .diagData     (diagData)
  );

endmodule

// ==== tbCshModel.svh ====
`ifndef TB_CSH_MODEL_SVH
`define TB_CSH_MODEL_SVH

`include "csh_params.svh"

  // MB first, CCA last
  function automatic cycTypeT priorityWinner(input logic mb, input logic chan,
                                             input logic ebox, input logic cca);
    cycTypeT w;
    w = '0;
    if (mb) begin
      w = 4'b1000;
    end else if (chan) begin
      w = 4'b0100;
    end else if (ebox) begin
      w = 4'b0010;
    end else if (cca) begin
      w = 4'b0001;
    end
    return w;
  endfunction

  // Result bits 5..0: mboxResp coreRdReq writeback chanHit ccaInval ccaWriteback
  function automatic logic [5:0] expectedResult(input cycTypeT ct, input wayVecT vm,
                                                input wayVecT aw, input wayVecT wv,
                                                input lruT lru, input logic cb);
    logic       hit;
    logic       found;
    logic       dirtyHit;
    logic [5:0] r;
    hit      = 1'b0;
    found    = 1'b0;
    dirtyHit = 1'b0;
    r        = '0;
    for (int w = 0; w < `CSH_WAYS; w++) begin
      if (vm[w]) begin
        hit      = 1'b1;
        found    = found | wv[w];
        dirtyHit = dirtyHit | aw[w];
      end
    end
    case (ct)
      4'b0010: begin
        if (found) begin
          r[5] = 1'b1;
        end else if (hit) begin
          r[4] = 1'b1;
        end else if (cb && aw[lru]) begin
          r[3] = 1'b1;
        end else begin
          r[4] = 1'b1;
        end
      end
      4'b0100: r[2] = hit;
      4'b0001: begin
        if (dirtyHit) begin
          r[0] = 1'b1;
        end else begin
          r[1] = hit;
        end
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  // Phase 0 is idle, 1 to 4 are T0 to T3
  function automatic diagWordT diagWord(input logic en, input diagSelT sel,
                                        input cycTypeT ct, input logic [2:0] ph,
                                        input logic [5:0] res);
    logic [3:0] tBits;
    tBits = (ph == 3'd0) ? 4'b0000 : 4'b0001 << (ph - 3'd1);
    if (!en) begin
      return '0;
    end
    case (sel)
      diagSelT'(0): return diagWordT'({ct, tBits});
      diagSelT'(1): return diagWordT'(res);
      default: return '0;
    endcase
  endfunction

`endif

// ==== tbCsh.sv ====
`timescale 1ns/1ps
`include "csh_params.svh"

module tbCsh;

  import cshPkg::*;

  `include "tbCshModel.svh"

  localparam int nArb     = 15;
  localparam int nHeld    = 4;
  localparam int nEbox    = 64;
  localparam int nOther   = 24;
  localparam int nDiag    = 24;
  localparam int nLoads   = 5;
  localparam int numTrans = nArb + nHeld + nEbox + 3 * nOther + nDiag + nLoads;

  logic     clk = 1'b0;
  logic     rstN;
  logic     mbReq, chanReq, eboxReq, ccaReq;
  wayVecT   validMatch, anyWritten, wordValid;
  lruT      lruWay;
  logic     cacheBit;
  logic     diagLoad;
  diagSelT  diagSelIn;
  logic     diagEn;
  logic     mboxResp, coreRdReq, writeback, chanHit, ccaInval, ccaWriteback;
  diagWordT diagData;

  integer     seed;
  int         failCount = 0;
  logic [2:0] expPhase;
  cycTypeT    expType;
  logic [5:0] expRes;
  diagSelT    expSel;
  diagWordT   expDiag;
  logic [5:0] actRes;

  csh dut (
    .clk (clk), .rstN (rstN),
    .mbReq (mbReq), .chanReq (chanReq), .eboxReq (eboxReq), .ccaReq (ccaReq),
    .validMatch (validMatch), .anyWritten (anyWritten), .wordValid (wordValid),
    .lruWay (lruWay), .cacheBit (cacheBit),
    .diagLoad (diagLoad), .diagSelIn (diagSelIn), .diagEn (diagEn),
    .mboxResp (mboxResp), .coreRdReq (coreRdReq), .writeback (writeback),
    .chanHit (chanHit), .ccaInval (ccaInval), .ccaWriteback (ccaWriteback),
    .diagData (diagData)
  );

  always #5 clk = ~clk;

  task automatic abortRun();
    $display("TB FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkCycType(input cycTypeT exp, input cycTypeT act);
    if (act !== exp) begin
      failCount++;
      $display("FAIL cycType expected 0x%h actual 0x%h at %0t", exp, act, $time);
      abortRun();
    end
  endtask

  task automatic checkDiag(input diagWordT exp, input diagWordT act);
    if (act !== exp) begin
      failCount++;
      $display("FAIL diagData expected 0x%h actual 0x%h at %0t", exp, act, $time);
      abortRun();
    end
  endtask

  task automatic checkResults(input logic [5:0] exp, input logic [5:0] act);
    if (act !== exp) begin
      failCount++;
      $display("FAIL resultPulses expected 0x%h actual 0x%h at %0t", exp, act, $time);
      abortRun();
    end
  endtask

  // One request set for one clock, then the four clocks of the cycle
  task automatic runCycle(input logic [3:0] reqs, input logic forceMiss);
    wayVecT vm;
    vm = wayVecT'($random(seed));
    if (forceMiss) begin
      vm = '0;
    end
    @(posedge clk);
    {mbReq, chanReq, eboxReq, ccaReq} <= reqs;
    validMatch <= vm;
    anyWritten <= wayVecT'($random(seed));
    wordValid  <= wayVecT'($random(seed));
    lruWay     <= lruT'($random(seed));
    cacheBit   <= 1'($random(seed));
    @(posedge clk);
    {mbReq, chanReq, eboxReq, ccaReq} <= 4'b0000;
    repeat (4) @(posedge clk);
  endtask

  task automatic holdRequests(input logic [3:0] reqs, input int clocks);
    @(posedge clk);
    {mbReq, chanReq, eboxReq, ccaReq} <= reqs;
    repeat (clocks) @(posedge clk);
    {mbReq, chanReq, eboxReq, ccaReq} <= 4'b0000;
    repeat (6) @(posedge clk);
  endtask

  task automatic loadDiag(input diagSelT sel);
    @(posedge clk);
    diagLoad  <= 1'b1;
    diagSelIn <= sel;
    @(posedge clk);
    diagLoad  <= 1'b0;
  endtask

  // Cycle model, stepped on the same edges as the DUT
  always @(posedge clk) begin
    if (!rstN) begin
      expPhase <= 3'd0;
      expType  <= '0;
      expRes   <= '0;
      expSel   <= '0;
    end else begin
      if (diagLoad) begin
        expSel <= diagSelIn;
      end
      expRes <= '0;
      case (expPhase)
        3'd0: begin
          expType <= priorityWinner(mbReq, chanReq, eboxReq, ccaReq);
          if (mbReq || chanReq || eboxReq || ccaReq) begin
            expPhase <= 3'd1;
          end
        end
        3'd3: begin
          expRes   <= expectedResult(expType, validMatch, anyWritten, wordValid,
                                     lruWay, cacheBit);
          expPhase <= 3'd4;
        end
        3'd4: expPhase <= 3'd0;
        default: expPhase <= expPhase + 3'd1;
      endcase
    end
  end

  always @(negedge clk) begin
    actRes  = {mboxResp, coreRdReq, writeback, chanHit, ccaInval, ccaWriteback};
    expDiag = diagWord(diagEn, expSel, expType, expPhase, expRes);
    checkResults(expRes, actRes);
    if (diagEn && expSel == diagSelT'(0)) begin
      checkCycType(expType, cycTypeT'(diagData[`CSH_DIAG_W-1 -: 4]));
    end
    checkDiag(expDiag, diagData);
  end

  initial begin
    repeat (numTrans * 10 + 200) @(posedge clk);
    $display("Timeout: tests did not finish within %0d clocks", numTrans * 10 + 200);
    abortRun();
  end

  initial begin
    rstN       = 1'b0;
    mbReq      = 1'b0;
    chanReq    = 1'b0;
    eboxReq    = 1'b0;
    ccaReq     = 1'b0;
    validMatch = '0;
    anyWritten = '0;
    wordValid  = '0;
    lruWay     = '0;
    cacheBit   = 1'b0;
    diagLoad   = 1'b0;
    diagSelIn  = '0;
    diagEn     = 1'b1;
    seed       = 32'ha866_151f;
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkResults(6'b000000,
                 {mboxResp, coreRdReq, writeback, chanHit, ccaInval, ccaWriteback});
    checkDiag('0, diagData);
    for (int r = 1; r < 16; r++) begin
      runCycle(4'(r), 1'b0);
    end
    // EBOX beats CCA every time, regranted five clocks apart
    holdRequests(4'b0011, 15);
    for (int i = 0; i < nEbox; i++) begin
      runCycle(4'b0010, i[0]);
    end
    loadDiag(diagSelT'(1));
    for (int i = 0; i < nOther; i++) begin
      runCycle(4'b0100, 1'b0);
      runCycle(4'b0001, 1'b0);
      runCycle(4'b1000, 1'b0);
    end
    loadDiag(diagSelT'(0));
    for (int i = 0; i < nDiag / 3; i++) begin
      runCycle(4'($random(seed)), 1'b0);
    end
    loadDiag(diagSelT'(5));
    for (int i = 0; i < nDiag / 3; i++) begin
      runCycle(4'($random(seed)), 1'b0);
    end
    loadDiag(diagSelT'(1));
    @(posedge clk);
    diagEn <= 1'b0;
    for (int i = 0; i < nDiag / 3; i++) begin
      runCycle(4'($random(seed)), 1'b0);
    end
    repeat (2) @(posedge clk);
    if (failCount == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abortRun();
    end
  end

endmodule

// ==== list.f ====
+incdir+.
cshPkg.sv
cshArbiter.sv
cshTiming.sv
cshLookup.sv
cshDiag.sv
csh.sv
tbCsh.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbCsh -f list.f -o simCsh || exit 1
out=$(./obj_dir/simCsh 2>&1)
echo "$out"
echo "$out" | grep -q "TB PASSED" && exit 0 || exit 1
